// File: hw/spiPkg.sv
// SPI master shared definitions
// Clock ratios for the serial clock, the transfer width codes, the APB
// register map and the common word types used by the register block and
// the shift engine
package spiPkg;

  //////////////////////////////////////////////////
  // Clocking
  //////////////////////////////////////////////////

  // System clock and the two serial clock rates
  localparam int unsigned clkFreqHz  = 10_000_000;
  localparam int unsigned fastSclkHz = 1_000_000;
  localparam int unsigned slowSclkHz = 250_000;

  // The tick counter must hold the slow ratio
  localparam int unsigned tickW = 7;
  typedef logic [tickW-1:0] tickT;

  // Clock divisions per serial bit, the counter wraps at this value
  localparam tickT tickFast = tickT'(clkFreqHz / fastSclkHz);
  localparam tickT tickSlow = tickT'(clkFreqHz / slowSclkHz);

  // Serial clock goes high at the midpoint of a bit
  localparam tickT tickHalfFast = tickT'(tickFast / 2);
  localparam tickT tickHalfSlow = tickT'(tickSlow / 2);

  //////////////////////////////////////////////////
  // Data types and width codes
  //////////////////////////////////////////////////

  typedef logic [1:0]  widthT;
  typedef logic [31:0] dataT;
  typedef logic [7:0]  addrT;

  // Code 2'b11 is reserved and decodes as 8 bits
  localparam widthT width8  = 2'b00;
  localparam widthT width32 = 2'b01;
  localparam widthT width16 = 2'b10;

  //////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////

  localparam addrT regCtrl = 8'h00;
  localparam addrT regTx   = 8'h04;
  localparam addrT regRx   = 8'h08;
  localparam addrT regStat = 8'h0C;

endpackage

// File: hw/spiXferIf.sv
// Transfer bundle between the APB register block and the shift engine
// The register block issues a start pulse with the transfer settings,
// the engine answers with the received word and its ready flag
`timescale 1ns/1ps

interface spiXferIf;

  // Command side, stable while rdy is low
  logic              start;
  logic              fast;
  logic              msByteFirst;
  spiPkg::widthT     width;
  spiPkg::dataT      txData;

  // Result side
  spiPkg::dataT      rxData;
  logic              rdy;

  // Register block view
  modport ctrl (
    output start, fast, msByteFirst, width, txData,
    input  rxData, rdy
  );

  // Shift engine view
  modport engine (
    input  start, fast, msByteFirst, width, txData,
    output rxData, rdy
  );

endinterface

// File: hw/spiShifter.sv
// SPI mode 3 shift engine
// Divides the system clock into serial bit periods, counts bits up to
// the selected width and shifts one 32-bit register that both sends on
// mosi and collects miso. Bytes go out MS-byte or LS-byte first, bits
// within a byte always MSB first
`timescale 1ns/1ps

module spiShifter (
  input  logic     clk,
  input  logic     rstN,
  spiXferIf.engine xfer,
  input  logic     miso,
  output logic     mosi,
  output logic     sclk
);

  logic         is8;
  logic         is16;
  logic         is32;
  spiPkg::tickT tick;
  spiPkg::tickT tickMax;
  spiPkg::tickT tickHalf;
  logic         endTick;
  logic         lastBit;
  logic [4:0]   bitCnt;
  logic         rdyQ;
  spiPkg::dataT shReg;
  spiPkg::dataT lsNext;
  logic [3:0]   byteIn;

  //////////////////////////////////////////////////
  // Width and rate decode
  //////////////////////////////////////////////////

  assign is32 = (xfer.width == spiPkg::width32);
  assign is16 = (xfer.width == spiPkg::width16);
  // The reserved code falls through to 8 bits
  assign is8  = (xfer.width == spiPkg::width8) || !(is16 || is32);

  assign tickMax  = xfer.fast ? spiPkg::tickFast : spiPkg::tickSlow;
  assign tickHalf = xfer.fast ? spiPkg::tickHalfFast : spiPkg::tickHalfSlow;

  // A bit period ends when the tick counter wraps, which is the falling edge
  assign endTick = !rdyQ && (tick == tickMax);
  assign lastBit = is32 ? (bitCnt == 5'd31) : is16 ? (bitCnt == 5'd15) : (bitCnt == 5'd7);

  //////////////////////////////////////////////////
  // LS-byte-first reordering
  //////////////////////////////////////////////////

  // Each byte shifts left on its own, and its new LSB comes from the MSB
  // of the byte above, so byte 0 drains first while byte 1 moves down
  // behind it. miso enters at the top byte of the active width
  always_comb begin
    byteIn[0] = shReg[15];
    byteIn[1] = shReg[23];
    byteIn[2] = shReg[31];
    byteIn[3] = miso;
    if (is8) begin
      byteIn[0] = miso;
    end
    if (is16) begin
      byteIn[1] = miso;
    end
    for (int b = 0; b < 4; b++) begin
      lsNext[b*8 +: 8] = {shReg[b*8 +: 7], byteIn[b]};
    end
  end

  //////////////////////////////////////////////////
  // Counters and shift register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tick   <= '0;
      bitCnt <= '0;
      rdyQ   <= 1'b1;
      shReg  <= '1;
    end else begin
      // Tick counter only runs during a transfer
      if (rdyQ || endTick) begin
        tick <= '0;
      end else begin
        tick <= tick + 1'b1;
      end

      if (xfer.start) begin
        rdyQ   <= 1'b0;
        bitCnt <= '0;
        shReg  <= xfer.txData;
      end else if (endTick) begin
        if (lastBit) begin
          rdyQ <= 1'b1;
        end else begin
          bitCnt <= bitCnt + 1'b1;
        end
        // Plain left shift in MS-byte order, miso lands in bit 0
        shReg <= xfer.msByteFirst ? {shReg[30:0], miso} : lsNext;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // In LS-byte order the leading bit always sits at the top of byte 0
  always_comb begin
    if (rdyQ) begin
      mosi = 1'b1;
    end else if (!xfer.msByteFirst) begin
      mosi = shReg[7];
    end else begin
      mosi = is32 ? shReg[31] : is16 ? shReg[15] : shReg[7];
    end
  end

  // Low for the first half of a bit, high for the second, idle high
  assign sclk = rdyQ || (tick >= tickHalf);

  // Received word is zero-extended to the bus width
  assign xfer.rxData = is32 ? shReg : is16 ? {16'b0, shReg[15:0]} : {24'b0, shReg[7:0]};
  assign xfer.rdy    = rdyQ;

  // The register block must never start a second transfer mid-flight
  startWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
    xfer.start |-> rdyQ);

  // Speed, byte order and width hold still for the whole transfer
  ctrlStable: assert property (@(posedge clk) disable iff (!rstN)
    !rdyQ |-> ($stable(xfer.fast) && $stable(xfer.msByteFirst) && $stable(xfer.width)));

endmodule

// File: hw/spiApbRegs.sv
// APB3 register block for the SPI master
// Decodes zero-wait-state accesses, holds the control word and the
// transmit word, and turns a regTx write into a one-cycle start pulse.
// A regTx write during a transfer is refused with pslverr
`timescale 1ns/1ps

module spiApbRegs (
  input  logic         clk,
  input  logic         rstN,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  spiPkg::addrT paddr,
  input  spiPkg::dataT pwdata,
  output spiPkg::dataT prdata,
  output logic         pready,
  output logic         pslverr,
  spiXferIf.ctrl       xfer
);

  logic          access;
  logic          busy;
  logic          wrCtrl;
  logic          wrTx;
  logic          startQ;
  logic          fastQ;
  logic          msByteFirstQ;
  spiPkg::widthT widthQ;
  spiPkg::dataT  txQ;

  //////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////

  // Every access completes in its first access-phase cycle
  assign pready = 1'b1;
  assign access = psel && penable;

  // A pending start counts as busy, since rdy only drops a cycle later
  assign busy = !xfer.rdy || startQ;

  assign wrCtrl = access && pwrite && (paddr == spiPkg::regCtrl);
  assign wrTx   = access && pwrite && (paddr == spiPkg::regTx);

  // Refused transmit write, flagged for this access only
  assign pslverr = wrTx && busy;

  //////////////////////////////////////////////////
  // Control register and start pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fastQ        <= 1'b0;
      msByteFirstQ <= 1'b0;
      widthQ       <= spiPkg::width8;
      startQ       <= 1'b0;
    end else begin
      // Control writes are dropped mid-transfer so the engine sees stable settings
      if (wrCtrl && !busy) begin
        fastQ        <= pwdata[0];
        msByteFirstQ <= pwdata[1];
        widthQ       <= pwdata[3:2];
      end
      startQ <= wrTx && !busy;
    end
  end

  // Transmit word, loaded together with the start pulse
  always_ff @(posedge clk) begin
    if (wrTx && !busy) begin
      txQ <= pwdata;
    end
  end

  assign xfer.start       = startQ;
  assign xfer.fast        = fastQ;
  assign xfer.msByteFirst = msByteFirstQ;
  assign xfer.width       = widthQ;
  assign xfer.txData      = txQ;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  // regTx is write-only and reads back as zero like any unmapped offset
  always_comb begin
    prdata = '0;
    case (paddr)
      spiPkg::regCtrl: prdata = {28'b0, widthQ, msByteFirstQ, fastQ};
      spiPkg::regRx:   prdata = xfer.rxData;
      spiPkg::regStat: prdata = {31'b0, xfer.rdy};
      default:         prdata = '0;
    endcase
  end

  // Every APB setup phase is followed by its access phase on the next cycle
  setupThenAccess: assert property (@(posedge clk) disable iff (!rstN)
    (psel && !penable) |=> (psel && penable));

  // The engine answers each start pulse by dropping rdy one cycle later
  rdyAfterStart: assert property (@(posedge clk) disable iff (!rstN)
    xfer.start |=> !xfer.rdy);

endmodule

// File: hw/spiMaster.sv
// SPI master peripheral top level
// APB3 slave port on one side, SPI mode 3 pins on the other. The
// register block and the shift engine talk over one transfer bundle
`timescale 1ns/1ps

module spiMaster (
  input  logic         clk,
  input  logic         rstN,
  // APB slave port
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  spiPkg::addrT paddr,
  input  spiPkg::dataT pwdata,
  output spiPkg::dataT prdata,
  output logic         pready,
  output logic         pslverr,
  // SPI pins
  input  logic         miso,
  output logic         mosi,
  output logic         sclk
);

  //////////////////////////////////////////////////
  // Transfer bundle
  //////////////////////////////////////////////////

  spiXferIf xfer ();

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////

  spiApbRegs spiApbRegs_i (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .xfer    (xfer.ctrl)
  );

  //////////////////////////////////////////////////
  // Shift engine
  //////////////////////////////////////////////////

  spiShifter spiShifter_i (
    .clk  (clk),
    .rstN (rstN),
    .xfer (xfer.engine),
    .miso (miso),
    .mosi (mosi),
    .sclk (sclk)
  );

endmodule

// File: dv/spiMasterTb.sv
// Testbench for the SPI master peripheral
// Runs a table of transfers over APB with mosi looped back to miso. It checks
// the received word, the serial bit order, the bit rate, busy protection
// and the status register
`timescale 1ns/1ps

module spiMasterTb;

  localparam int  numTests    = 10;
  localparam time clkPeriod   = 100;
  // One serial bit spans tick+1 system clocks
  localparam int  bitClksFast = 11;
  localparam int  bitClksSlow = 41;
  // Ten transfers of at most 32 slow bits (1312 clocks), plus APB polling
  localparam int  cycleLimit  = 20000;

  logic          clk;
  logic          rstN;
  logic          psel;
  logic          penable;
  logic          pwrite;
  spiPkg::addrT  paddr;
  spiPkg::dataT  pwdata;
  spiPkg::dataT  prdata;
  logic          pready;
  logic          pslverr;
  logic          miso;
  logic          mosi;
  logic          sclk;
  integer        seed;
  int            cycleCnt;
  logic          bitQ[$];
  time           edgeQ[$];
  string         nameTab[numTests];
  spiPkg::dataT  txTab[numTests];
  spiPkg::widthT widthTab[numTests];
  logic          fastTab[numTests];
  logic          msbTab[numTests];

  spiMaster spiMaster_i (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk)
  );

  // Loopback, so every transfer should receive exactly what it sent
  assign miso = mosi;

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      $display("Timeout: the run went past %0d clock cycles", cycleLimit);
      $display("=== FAIL ===");
      $fatal(1, "simulation timed out");
    end
  end

  // Mode 3 slave view of the line, mosi is stable at the rising sclk edge
  always @(posedge sclk) begin
    if (rstN) begin
      bitQ.push_back(mosi);
      edgeQ.push_back($time);
    end
  end

  //////////////////////////////////////////////////
  // Expected values from the width code table
  //////////////////////////////////////////////////

  // 00 is 8 bits, 01 is 32, 10 is 16, and the reserved 11 acts as 8
  function automatic int widthBits(input spiPkg::widthT w);
    return (w == 2'b01) ? 32 : (w == 2'b10) ? 16 : 8;
  endfunction

  function automatic spiPkg::dataT maskWidth(input spiPkg::dataT tx, input int nBits);
    return (nBits == 32) ? tx : (nBits == 16) ? (tx & 32'h0000_FFFF) : (tx & 32'h0000_00FF);
  endfunction

  // Stream packed with the first bit on the line at position nBits-1
  function automatic spiPkg::dataT serialOrder(input spiPkg::dataT tx, input int nBits,
                                               input logic msFirst);
    spiPkg::dataT word;
    spiPkg::dataT stream;
    word   = maskWidth(tx, nBits);
    stream = '0;
    for (int k = 0; k < nBits / 8; k++) begin
      stream[(nBits / 8 - 1 - k) * 8 +: 8] = word[k * 8 +: 8];
    end
    return msFirst ? word : stream;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkData(input string name, input spiPkg::dataT exp, input spiPkg::dataT act);
    if (act !== exp) begin
      failNow($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic checkBits(input string name, input spiPkg::dataT exp, input spiPkg::dataT act);
    if (act !== exp) begin
      failNow($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      failNow($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // APB tasks, entered and left 10 ns after a rising edge
  //////////////////////////////////////////////////

  task automatic apbAccess(input logic wr, input spiPkg::addrT addr, input spiPkg::dataT wdata,
                           output spiPkg::dataT rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #10;
    penable = 1'b1;
    // Zero wait states, so the response is valid mid-cycle of the access phase
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    checkFlag("apbReady", 1'b1, pready);
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbWrite(input spiPkg::addrT addr, input spiPkg::dataT wdata, output logic err);
    spiPkg::dataT rdata;
    apbAccess(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic apbRead(input spiPkg::addrT addr, output spiPkg::dataT rdata);
    logic err;
    apbAccess(1'b0, addr, '0, rdata, err);
  endtask

  // Polls status until rdy returns, the cycle limit guards against a hang
  task automatic waitReady();
    spiPkg::dataT rdata;
    rdata = '0;
    while (rdata[0] !== 1'b1) begin
      apbRead(spiPkg::regStat, rdata);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic addEntry(input int idx, input string name, input spiPkg::dataT tx,
                          input spiPkg::widthT w, input logic fast, input logic msb);
    nameTab[idx]  = name;
    txTab[idx]    = tx;
    widthTab[idx] = w;
    fastTab[idx]  = fast;
    msbTab[idx]   = msb;
  endtask

  task automatic fillTable();
    // Upper bits are set on narrow words to show the zero extension
    addEntry(0, "ms8Fast", 32'hFFFF_FFA5, 2'b00, 1'b1, 1'b1);
    addEntry(1, "ls8Slow", 32'h5A5A_5A3C, 2'b00, 1'b0, 1'b0);
    addEntry(2, "ms16Fast", 32'hC3C3_B4E1, 2'b10, 1'b1, 1'b1);
    addEntry(3, "ls16Fast", 32'h8765_12F0, 2'b10, 1'b1, 1'b0);
    addEntry(4, "ms32Fast", 32'hDEAD_BEEF, 2'b01, 1'b1, 1'b1);
    addEntry(5, "ls32Fast", 32'h0123_4567, 2'b01, 1'b1, 1'b0);
    addEntry(6, "rsvdFast", $random(seed), 2'b11, 1'b1, 1'b1);
    addEntry(7, "ls32Slow", $random(seed), 2'b01, 1'b0, 1'b0);
    addEntry(8, "ms16Slow", $random(seed), 2'b10, 1'b0, 1'b1);
    addEntry(9, "ls16Rand", $random(seed), 2'b10, 1'b1, 1'b0);
  endtask

  task automatic runTransfer(input int idx);
    spiPkg::dataT rdata;
    spiPkg::dataT stream;
    logic         err;
    int           nBits;
    string        name;
    name  = nameTab[idx];
    nBits = widthBits(widthTab[idx]);
    apbWrite(spiPkg::regCtrl, {28'b0, widthTab[idx], msbTab[idx], fastTab[idx]}, err);
    checkFlag({name, "CtrlErr"}, 1'b0, err);
    bitQ.delete();
    edgeQ.delete();
    apbWrite(spiPkg::regTx, txTab[idx], err);
    checkFlag({name, "TxErr"}, 1'b0, err);
    // A second word while the first is in flight must be refused
    apbWrite(spiPkg::regTx, ~txTab[idx], err);
    checkFlag({name, "BusyErr"}, 1'b1, err);
    apbRead(spiPkg::regStat, rdata);
    checkData({name, "BusyStat"}, 32'h0, rdata);
    waitReady();
    checkFlag({name, "IdleSclk"}, 1'b1, sclk);
    checkFlag({name, "IdleMosi"}, 1'b1, mosi);
    apbRead(spiPkg::regRx, rdata);
    checkData({name, "Rx"}, maskWidth(txTab[idx], nBits), rdata);
    checkBits({name, "EdgeCount"}, spiPkg::dataT'(nBits), spiPkg::dataT'(bitQ.size()));
    stream = '0;
    foreach (bitQ[b]) begin
      stream = {stream[30:0], bitQ[b]};
    end
    checkBits({name, "Stream"}, serialOrder(txTab[idx], nBits, msbTab[idx]), stream);
    for (int e = 1; e < edgeQ.size(); e++) begin
      checkBits({name, "Spacing"}, spiPkg::dataT'(fastTab[idx] ? bitClksFast : bitClksSlow),
                spiPkg::dataT'((edgeQ[e] - edgeQ[e - 1]) / clkPeriod));
    end
  endtask

  initial begin
    spiPkg::dataT rdata;
    clk      = 1'b0;
    rstN     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    cycleCnt = 0;
    seed     = 32'h9cfc_ce62;
    fillTable();
    repeat (5) @(posedge clk);
    #10;
    rstN = 1'b1;
    @(posedge clk);
    #10;
    // Idle state out of reset, the control word starts at width code 00
    checkFlag("resetSclk", 1'b1, sclk);
    checkFlag("resetMosi", 1'b1, mosi);
    apbRead(spiPkg::regStat, rdata);
    checkFlag("resetRdy", 1'b1, rdata[0]);
    apbRead(spiPkg::regRx, rdata);
    checkData("resetRx", 32'h0000_00FF, rdata);
    for (int i = 0; i < numTests; i++) begin
      runTransfer(i);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: spiMaster.f
hw/spiPkg.sv
hw/spiXferIf.sv
hw/spiShifter.sv
hw/spiApbRegs.sv
hw/spiMaster.sv
dv/spiMasterTb.sv

// File: Makefile
# Verilator build and run for the SPI master testbench
TOP := spiMasterTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f spiMaster.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
